/* rtl/soc_io_pkg.sv */
//--------------------------------------------------------------------
// io address map and shared types for the basys3 io side
// targets are picked by the top address byte and, for the uart, the low offset
// gpio region ignores the low 24 address bits
//--------------------------------------------------------------------
`default_nettype none

package soc_io_pkg;

	// bus widths
	localparam int IO_DW = 32;          // data and address width
	localparam int IO_BW = IO_DW / 8;   // byte lanes, one strobe each
	localparam int HALF_W = IO_DW / 2;  // sw / led halves of the gpio word

	// region select, address bits 31:24
	localparam logic [7:0] GPIO_BASE = 8'h03;
	localparam logic [7:0] UART_BASE = 8'h02;

	// uart register offsets inside its region
	localparam logic [7:0] UART_DIV_OFS = 8'h04;   // clocks per bit minus one
	localparam logic [7:0] UART_DAT_OFS = 8'h08;   // tx on write, rx buffer on read

	// gpio readback, switches high and led lanes low
	typedef struct packed {
		logic [HALF_W-1:0] sw;
		logic [HALF_W-1:0] led;
	} gpio_fields_t;

	typedef union packed {
		logic [IO_DW-1:0] raw;   // as seen on the bus
		gpio_fields_t fld;       // decoded view
	} gpio_word_u;

	// decoder target, latched per request
	typedef enum logic [1:0] {
		sel_none,       // unmapped, answered by the decoder
		sel_gpio,
		sel_uart_div,
		sel_uart_dat
	} io_sel_e;

endpackage

`default_nettype wire

/* rtl/reset_gen.sv */
//--------------------------------------------------------------------
// stretches the board reset by RESET_CYCLES clocks
// resetn is sampled on clk_bufg and must already be synchronous
//--------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module reset_gen #(
	parameter int RESET_CYCLES = 63
) (
	input  logic clk_bufg,
	input  logic resetn,
	output logic sys_resetn
);

	localparam int CNT_W = $clog2(RESET_CYCLES + 1);

	logic [CNT_W-1:0] cnt;
	logic cnt_full;

	assign cnt_full = (cnt == CNT_W'(RESET_CYCLES));

	always_ff @(posedge clk_bufg) begin
		if (!resetn) begin
			cnt <= '0;                       // restart the stretch
		end else if (!cnt_full) begin
			cnt <= cnt + CNT_W'(1);          // saturates at RESET_CYCLES
		end
	end

	// system leaves reset only once the count is complete
	assign sys_resetn = cnt_full;

endmodule

`default_nettype wire

/* rtl/iomem_decode.sv */
//--------------------------------------------------------------------
// iomem address decoder with one outstanding request at a time
// master holds addr and wstrb until ready; ready is a one cycle pulse
// unmapped accesses get ready after one cycle with zero rdata
//--------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module iomem_decode (
	input  logic clk_bufg,
	input  logic sys_resetn,
	input  logic iomem_valid,
	input  logic [soc_io_pkg::IO_BW-1:0] iomem_wstrb,
	input  logic [soc_io_pkg::IO_DW-1:0] iomem_addr,
	output logic iomem_ready,
	output logic [soc_io_pkg::IO_DW-1:0] iomem_rdata,
	output logic gpio_sel,
	output logic uart_div_sel,
	output logic uart_dat_sel,
	input  logic gpio_ready,
	input  soc_io_pkg::gpio_word_u gpio_rdata,
	input  logic uart_ready,
	input  logic [soc_io_pkg::IO_DW-1:0] uart_rdata
);
	import soc_io_pkg::*;

	io_sel_e cur_sel;    // decode of the address on the bus now
	io_sel_e io_sel_q;   // target of the pending request
	logic none_ready;    // our own answer for unmapped space

	always_comb begin
		cur_sel = sel_none;
		if (iomem_addr[31:24] == GPIO_BASE) begin
			cur_sel = sel_gpio;                          // whole region
		end else if (iomem_addr[31:24] == UART_BASE) begin
			if (iomem_addr[23:0] == 24'(UART_DIV_OFS))
				cur_sel = sel_uart_div;
			else if (iomem_addr[23:0] == 24'(UART_DAT_OFS))
				cur_sel = sel_uart_dat;
		end
	end

	// selects follow valid so a target sees the whole pending window
	assign gpio_sel     = iomem_valid && (cur_sel == sel_gpio);
	assign uart_div_sel = iomem_valid && (cur_sel == sel_uart_div);
	assign uart_dat_sel = iomem_valid && (cur_sel == sel_uart_dat);

	always_ff @(posedge clk_bufg) begin
		if (!sys_resetn) begin
			none_ready <= 1'b0;
			io_sel_q   <= sel_none;
		end else begin
			// single pulse even while valid is still held
			none_ready <= iomem_valid && (cur_sel == sel_none) && !none_ready;
			if (iomem_valid && !iomem_ready)
				io_sel_q <= cur_sel;                         // held through the ready cycle
		end
	end

	assign iomem_ready = gpio_ready | uart_ready | none_ready;

	always_comb begin
		case (io_sel_q)
			sel_gpio:                   iomem_rdata = gpio_rdata.raw;
			sel_uart_div, sel_uart_dat: iomem_rdata = uart_rdata;   // uart picks its own reg
			default:                    iomem_rdata = '0;           // unmapped reads as zero
		endcase
	end

	// a target must never answer a request that is not there
	a_ready_needs_valid: assert property (@(posedge clk_bufg) disable iff (!sys_resetn)
		iomem_ready |-> iomem_valid);

	a_sel_onehot: assert property (@(posedge clk_bufg) disable iff (!sys_resetn)
		$onehot0({gpio_sel, uart_div_sel, uart_dat_sel}));

	// master keeps the request steady until it sees ready
	a_req_stable: assert property (@(posedge clk_bufg) disable iff (!sys_resetn)
		iomem_valid && !iomem_ready |=>
			iomem_valid && $stable(iomem_addr) && $stable(iomem_wstrb));

endmodule

`default_nettype wire

/* rtl/gpio_regs.sv */
//--------------------------------------------------------------------
// 32 bit gpio register, led driven from bits 15:0
// bits 31:16 are writable but read back as the switch inputs
//--------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module gpio_regs (
	input  logic clk_bufg,
	input  logic sys_resetn,
	input  logic sel,
	input  logic [soc_io_pkg::IO_BW-1:0] wstrb,
	input  logic [soc_io_pkg::IO_DW-1:0] wdata,
	input  logic [soc_io_pkg::HALF_W-1:0] sw,
	output logic ready,
	output soc_io_pkg::gpio_word_u rdata,
	output logic [soc_io_pkg::HALF_W-1:0] led
);
	import soc_io_pkg::*;

	logic [IO_DW-1:0] gpio;
	logic acc;   // first cycle of a selected request

	assign acc = sel && !ready;   // held request answered once

	always_ff @(posedge clk_bufg) begin
		if (!sys_resetn) begin
			gpio  <= '0;
			ready <= 1'b0;
		end else begin
			ready <= acc;
			if (acc) begin
				for (int i = 0; i < IO_BW; i++) begin
					if (wstrb[i])
						gpio[i*8 +: 8] <= wdata[i*8 +: 8];   // per byte lane
				end
			end
		end
	end

	// readback snapshot, taken before this request's write lands
	always_ff @(posedge clk_bufg) begin
		if (acc) begin
			rdata.fld.sw  <= sw;
			rdata.fld.led <= gpio[HALF_W-1:0];
		end
	end

	assign led = gpio[HALF_W-1:0];

	a_ready_pulse: assert property (@(posedge clk_bufg) disable iff (!sys_resetn)
		ready |=> !ready);

endmodule

`default_nettype wire

/* rtl/simple_uart.sv */
//--------------------------------------------------------------------
// 8N1 serial port, each bit lasts divider+1 clocks
// data write waits while a frame is going out; read pops one byte or all ones
// rx frames with a bad stop bit are dropped
//--------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module simple_uart #(
	parameter int UART_DIV_INIT = 16
) (
	input  logic clk_bufg,
	input  logic sys_resetn,
	input  logic div_sel,
	input  logic dat_sel,
	input  logic [soc_io_pkg::IO_BW-1:0] wstrb,
	input  logic [soc_io_pkg::IO_DW-1:0] wdata,
	input  logic rx,
	output logic ready,
	output logic [soc_io_pkg::IO_DW-1:0] rdata,
	output logic tx
);
	import soc_io_pkg::*;

	// rx fsm states
	localparam logic [1:0] RX_IDLE  = 2'd0;
	localparam logic [1:0] RX_START = 2'd1;
	localparam logic [1:0] RX_DATA  = 2'd2;
	localparam logic [1:0] RX_STOP  = 2'd3;

	logic [IO_DW-1:0] divider;     // clocks per bit minus one
	logic div_acc, dat_wr_acc, dat_rd_acc;

	logic [9:0] tx_pattern;        // stop, data, start; lsb goes out first
	logic [3:0] tx_bitcnt;         // bits left in the frame
	logic [IO_DW-1:0] tx_divcnt;
	logic tx_idle;

	logic [1:0] rx_sync;           // two flop synchronizer
	logic [1:0] rx_state;
	logic [2:0] rx_bitcnt;
	logic [IO_DW-1:0] rx_divcnt;
	logic [IO_DW-1:0] rx_half;
	logic rx_tick;                 // one bit period elapsed
	logic rx_done;                 // good stop bit seen
	logic [7:0] rx_shift;
	logic [7:0] rx_buf;
	logic rx_buf_valid;

	assign tx_idle = (tx_bitcnt == 4'd0);

	// accept once per request; data write also needs an idle transmitter
	assign div_acc    = div_sel && !ready;
	assign dat_wr_acc = dat_sel && (|wstrb) && !ready && tx_idle;
	assign dat_rd_acc = dat_sel && !(|wstrb) && !ready;

	always_ff @(posedge clk_bufg) begin
		if (!sys_resetn) begin
			divider <= IO_DW'(UART_DIV_INIT);
			ready   <= 1'b0;
		end else begin
			ready <= div_acc | dat_wr_acc | dat_rd_acc;   // low while tx busy
			if (div_acc) begin
				for (int i = 0; i < IO_BW; i++) begin
					if (wstrb[i])
						divider[i*8 +: 8] <= wdata[i*8 +: 8];
				end
			end
		end
	end

	// transmit shifter
	always_ff @(posedge clk_bufg) begin
		if (!sys_resetn) begin
			tx_pattern <= '1;              // line idles high
			tx_bitcnt  <= 4'd0;
			tx_divcnt  <= '0;
		end else if (dat_wr_acc) begin
			tx_pattern <= {1'b1, wdata[7:0], 1'b0};
			tx_bitcnt  <= 4'd10;
			tx_divcnt  <= '0;
		end else if (!tx_idle) begin
			if (tx_divcnt >= divider) begin   // >= survives a divider change mid frame
				tx_divcnt  <= '0;
				tx_pattern <= {1'b1, tx_pattern[9:1]};   // ones fill behind
				tx_bitcnt  <= tx_bitcnt - 4'd1;
			end else begin
				tx_divcnt <= tx_divcnt + 1'b1;
			end
		end
	end

	assign tx = tx_pattern[0];

	assign rx_half = {1'b0, divider[IO_DW-1:1]};
	assign rx_tick = (rx_divcnt >= divider);
	assign rx_done = (rx_state == RX_STOP) && rx_tick && rx_sync[1];

	// receive fsm, start checked at half a bit then full periods land mid bit
	always_ff @(posedge clk_bufg) begin
		if (!sys_resetn) begin
			rx_sync      <= 2'b11;
			rx_state     <= RX_IDLE;
			rx_bitcnt    <= 3'd0;
			rx_divcnt    <= '0;
			rx_buf_valid <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			if (dat_rd_acc)
				rx_buf_valid <= 1'b0;
			if (rx_done)
				rx_buf_valid <= 1'b1;              // new byte wins over a read
			case (rx_state)
				RX_IDLE: begin
					rx_divcnt <= '0;
					if (!rx_sync[1])
						rx_state <= RX_START;        // falling edge
				end
				RX_START: begin
					if (rx_divcnt >= rx_half) begin
						rx_divcnt <= '0;
						rx_bitcnt <= 3'd0;
						rx_state  <= rx_sync[1] ? RX_IDLE : RX_DATA;   // glitch check
					end else begin
						rx_divcnt <= rx_divcnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (rx_tick) begin
						rx_divcnt <= '0;
						rx_bitcnt <= rx_bitcnt + 3'd1;
						if (rx_bitcnt == 3'd7)
							rx_state <= RX_STOP;
					end else begin
						rx_divcnt <= rx_divcnt + 1'b1;
					end
				end
				default: begin               // stop bit
					if (rx_tick)
						rx_state <= RX_IDLE;
					else
						rx_divcnt <= rx_divcnt + 1'b1;
				end
			endcase
		end
	end

	// data path registers
	always_ff @(posedge clk_bufg) begin
		if ((rx_state == RX_DATA) && rx_tick)
			rx_shift <= {rx_sync[1], rx_shift[7:1]};   // lsb first
		if (rx_done)
			rx_buf <= rx_shift;
		if (div_acc)
			rdata <= divider;
		else if (dat_rd_acc)
			rdata <= rx_buf_valid ? {24'h0, rx_buf} : '1;   // all ones = empty
		else if (dat_wr_acc)
			rdata <= '0;
	end

	// shifter must leave the line high between frames
	a_tx_idle_high: assert property (@(posedge clk_bufg) disable iff (!sys_resetn)
		tx_idle |-> tx);

endmodule

`default_nettype wire

/* rtl/basys3_io_top.sv */
//--------------------------------------------------------------------
// basys3 io side, gpio at 0x03xxxxxx and uart at 0x02000004 / 0x02000008
// clk_bufg must come already buffered; resetn is active low and synchronous
// bus master sits outside, one request at a time
//--------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module basys3_io_top #(
	parameter int RESET_CYCLES  = 63,   // reset stretch in clocks
	parameter int UART_DIV_INIT = 16    // divider register after reset
) (
	input  logic clk_bufg,
	input  logic resetn,
	input  logic iomem_valid,
	output logic iomem_ready,
	input  logic [soc_io_pkg::IO_BW-1:0] iomem_wstrb,
	input  logic [soc_io_pkg::IO_DW-1:0] iomem_addr,
	input  logic [soc_io_pkg::IO_DW-1:0] iomem_wdata,
	output logic [soc_io_pkg::IO_DW-1:0] iomem_rdata,
	input  logic [soc_io_pkg::HALF_W-1:0] sw,
	output logic [soc_io_pkg::HALF_W-1:0] led,
	input  logic rx,
	output logic tx
);
	import soc_io_pkg::*;

	logic sys_resetn;
	logic gpio_sel, uart_div_sel, uart_dat_sel;
	logic gpio_ready, uart_ready;
	gpio_word_u gpio_rdata;
	logic [IO_DW-1:0] uart_rdata;

	reset_gen #(
		.RESET_CYCLES (RESET_CYCLES)
	) u_reset_gen (
		.clk_bufg   (clk_bufg),
		.resetn     (resetn),
		.sys_resetn (sys_resetn)
	);

	iomem_decode u_decode (
		.clk_bufg     (clk_bufg),
		.sys_resetn   (sys_resetn),
		.iomem_valid  (iomem_valid),
		.iomem_wstrb  (iomem_wstrb),
		.iomem_addr   (iomem_addr),
		.iomem_ready  (iomem_ready),
		.iomem_rdata  (iomem_rdata),
		.gpio_sel     (gpio_sel),
		.uart_div_sel (uart_div_sel),
		.uart_dat_sel (uart_dat_sel),
		.gpio_ready   (gpio_ready),
		.gpio_rdata   (gpio_rdata),
		.uart_ready   (uart_ready),
		.uart_rdata   (uart_rdata)
	);

	// wstrb and wdata go straight to both targets
	gpio_regs u_gpio (
		.clk_bufg   (clk_bufg),
		.sys_resetn (sys_resetn),
		.sel        (gpio_sel),
		.wstrb      (iomem_wstrb),
		.wdata      (iomem_wdata),
		.sw         (sw),
		.ready      (gpio_ready),
		.rdata      (gpio_rdata),
		.led        (led)
	);

	simple_uart #(
		.UART_DIV_INIT (UART_DIV_INIT)
	) u_uart (
		.clk_bufg   (clk_bufg),
		.sys_resetn (sys_resetn),
		.div_sel    (uart_div_sel),
		.dat_sel    (uart_dat_sel),
		.wstrb      (iomem_wstrb),
		.wdata      (iomem_wdata),
		.rx         (rx),
		.ready      (uart_ready),
		.rdata      (uart_rdata),
		.tx         (tx)
	);

endmodule

`default_nettype wire

/* bench/tb_basys3_io.sv */
//----------------------------------------------------------------------
// directed testbench for basys3_io_top, one bus request at a time
// serial checks run at TEST_DIV, the largest divider written here
// reset stretch is timed on the internal sys_resetn of the DUT
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_basys3_io;
	import soc_io_pkg::*;

	localparam int RESET_CYCLES = 63;
	localparam int DIV_INIT = 16;
	localparam int TEST_DIV = 20;                        // largest divider used
	localparam int FRAME_CLKS = 10 * (TEST_DIV + 1);
	localparam int CYCLE_LIMIT = 6 * FRAME_CLKS + 600;   // reset and gpio traffic fit in margin
	localparam logic [IO_DW-1:0] GPIO_ADDR = {GPIO_BASE, 24'h00_0010};
	localparam logic [IO_DW-1:0] DIV_ADDR = {UART_BASE, 16'h0, UART_DIV_OFS};
	localparam logic [IO_DW-1:0] DAT_ADDR = {UART_BASE, 16'h0, UART_DAT_OFS};
	localparam logic [IO_DW-1:0] BAD_ADDR = 32'h0400_0000;
	localparam logic [IO_DW-1:0] HOLE_ADDR = {UART_BASE, 24'h00_000c};   // uart region, no reg

	logic clk_bufg;
	logic resetn;
	logic iomem_valid;
	logic iomem_ready;
	logic [IO_BW-1:0] iomem_wstrb;
	logic [IO_DW-1:0] iomem_addr;
	logic [IO_DW-1:0] iomem_wdata;
	logic [IO_DW-1:0] iomem_rdata;
	logic [HALF_W-1:0] sw;
	logic [HALF_W-1:0] led;
	logic rx;
	logic tx;
	logic loop_en;                  // serial model, tx looped to rx
	logic rx_drv;                   // serial model, driven line
	logic [IO_DW-1:0] gpio_model;   // byte merge of all gpio writes
	int cycles = 0;

	assign rx = loop_en ? tx : rx_drv;

	basys3_io_top #(
		.RESET_CYCLES  (RESET_CYCLES),
		.UART_DIV_INIT (DIV_INIT)
	) uut (
		.clk_bufg    (clk_bufg),
		.resetn      (resetn),
		.iomem_valid (iomem_valid),
		.iomem_ready (iomem_ready),
		.iomem_wstrb (iomem_wstrb),
		.iomem_addr  (iomem_addr),
		.iomem_wdata (iomem_wdata),
		.iomem_rdata (iomem_rdata),
		.sw          (sw),
		.led         (led),
		.rx          (rx),
		.tx          (tx)
	);

	initial begin
		clk_bufg = 1'b0;
		forever #20 clk_bufg = ~clk_bufg;   // 40 ns period
	end

	always @(posedge clk_bufg) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			abort_run($sformatf("timeout, run did not finish in %0d clock cycles", CYCLE_LIMIT));
	end

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_word(input logic [IO_DW-1:0] got, input logic [IO_DW-1:0] exp,
			input string what);
		if (got !== exp)
			abort_run($sformatf("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp));
	endtask

	task automatic check_gpio(input gpio_word_u got, input gpio_word_u exp, input string what);
		if (got.fld.sw !== exp.fld.sw)
			abort_run($sformatf("ERROR at %0t ns: %s sw field got %h expected %h",
				$time, what, got.fld.sw, exp.fld.sw));
		if (got.fld.led !== exp.fld.led)
			abort_run($sformatf("ERROR at %0t ns: %s led field got %h expected %h",
				$time, what, got.fld.led, exp.fld.led));
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp));
	endtask

	// one request; lat counts rising edges until ready
	task automatic io_access(input logic [IO_DW-1:0] addr, input logic [IO_BW-1:0] strb,
			input logic [IO_DW-1:0] data, output logic [IO_DW-1:0] rd, output int lat);
		lat = 0;
		@(posedge clk_bufg);
		#2;
		iomem_valid = 1'b1;
		iomem_addr  = addr;
		iomem_wstrb = strb;
		iomem_wdata = data;
		do begin
			@(posedge clk_bufg);
			lat++;
			@(negedge clk_bufg);   // ready and rdata settled here
		end while (iomem_ready !== 1'b1);
		rd = iomem_rdata;
		@(posedge clk_bufg);
		#2;
		iomem_valid = 1'b0;
		iomem_wstrb = '0;
	endtask

	task automatic io_write(input logic [IO_DW-1:0] addr, input logic [IO_DW-1:0] data,
			input logic [IO_BW-1:0] strb, output int lat);
		logic [IO_DW-1:0] unused_rd;
		io_access(addr, strb, data, unused_rd, lat);
	endtask

	task automatic io_read(input logic [IO_DW-1:0] addr, output logic [IO_DW-1:0] rd,
			output int lat);
		io_access(addr, '0, '0, rd, lat);
	endtask

	// decode one tx frame, sampling mid bit
	task automatic receive_frame(input int div, output logic [7:0] data);
		@(negedge tx);
		repeat ((div + 1) / 2) @(posedge clk_bufg);
		@(negedge clk_bufg);
		if (tx !== 1'b0)
			abort_run("tx start bit did not stay low up to mid bit");
		for (int i = 0; i < 8; i++) begin
			repeat (div + 1) @(negedge clk_bufg);
			data[i] = tx;   // lsb first
		end
		repeat (div + 1) @(negedge clk_bufg);
		if (tx !== 1'b1)
			abort_run("tx stop bit was not high");
	endtask

	// drive one 8N1 frame on rx
	task automatic send_frame(input int div, input logic [7:0] data);
		logic [9:0] bits;
		bits = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk_bufg);
			#2;
			rx_drv = bits[i];
			repeat (div) @(posedge clk_bufg);   // div+1 clocks per bit
		end
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		do begin
			@(posedge clk_bufg);
			n++;
			@(negedge clk_bufg);
		end while (uut.sys_resetn !== 1'b1);
		check_word(IO_DW'(n), IO_DW'(RESET_CYCLES), "reset stretch length");
	endtask

	task automatic test_reset_state();
		logic [IO_DW-1:0] rd;
		gpio_word_u exp;
		int lat;
		check_word(IO_DW'(led), '0, "led after reset");
		check_word({31'h0, tx}, 32'h1, "tx after reset");
		io_read(GPIO_ADDR, rd, lat);
		check_word(IO_DW'(lat), 32'd1, "gpio read latency");
		exp.fld.sw  = sw;
		exp.fld.led = '0;
		check_gpio(rd, exp, "gpio read after reset");
		io_read(DIV_ADDR, rd, lat);
		check_word(rd, IO_DW'(DIV_INIT), "divider after reset");
	endtask

	task automatic test_gpio_strobes();
		logic [IO_DW-1:0] data;
		logic [IO_DW-1:0] rd;
		logic [IO_BW-1:0] strb;
		gpio_word_u exp;
		int lat;
		gpio_model = '0;
		for (int i = 0; i <= IO_BW; i++) begin
			sw   = HALF_W'($urandom);
			data = $urandom;
			strb = (i < IO_BW) ? IO_BW'(1 << i) : '1;   // each lane, then all
			io_write(GPIO_ADDR, data, strb, lat);
			check_word(IO_DW'(lat), 32'd1, "gpio write latency");
			for (int b = 0; b < IO_BW; b++) begin
				if (strb[b])
					gpio_model[b*8 +: 8] = data[b*8 +: 8];
			end
			check_word(IO_DW'(led), IO_DW'(gpio_model[HALF_W-1:0]), "led after strobed write");
			io_read(GPIO_ADDR, rd, lat);
			exp.fld.sw  = sw;
			exp.fld.led = gpio_model[HALF_W-1:0];
			check_gpio(rd, exp, "gpio readback");
		end
	endtask

	task automatic test_decode();
		logic [HALF_W-1:0] led_before;
		logic [IO_DW-1:0] rd;
		int lat;
		led_before = led;
		io_write(BAD_ADDR, $urandom, '1, lat);
		check_word(IO_DW'(lat), 32'd1, "unmapped write latency");
		check_word(IO_DW'(led), IO_DW'(led_before), "led after unmapped write");
		io_read(BAD_ADDR, rd, lat);
		check_word(IO_DW'(lat), 32'd1, "unmapped read latency");
		check_word(rd, '0, "unmapped read data");
		io_read(HOLE_ADDR, rd, lat);
		check_word(rd, '0, "uart hole read data");
	endtask

	task automatic test_transmit();
		logic [IO_DW-1:0] rd;
		logic [7:0] b1, b2, got1, got2;
		logic first_done, held_off;
		int lat, lat1, lat2;
		io_write(DIV_ADDR, IO_DW'(TEST_DIV), '1, lat);
		check_word(IO_DW'(lat), 32'd1, "divider write latency");
		io_read(DIV_ADDR, rd, lat);
		check_word(rd, IO_DW'(TEST_DIV), "divider readback");
		b1 = 8'($urandom);
		b2 = 8'($urandom);
		first_done = 1'b0;
		held_off = 1'b0;
		loop_en = 1'b1;   // receiver sees both frames too
		fork
			begin
				receive_frame(TEST_DIV, got1);
				first_done = 1'b1;
				receive_frame(TEST_DIV, got2);
			end
			begin
				io_write(DAT_ADDR, {24'h0, b1}, 4'h1, lat1);
				io_write(DAT_ADDR, {24'h0, b2}, 4'h1, lat2);   // lands while b1 goes out
				held_off = first_done;
			end
		join
		check_word(IO_DW'(lat1), 32'd1, "data write latency with idle tx");
		check_byte(got1, b1, "first tx frame");
		check_byte(got2, b2, "second tx frame");
		if (!held_off || lat2 <= 1)
			abort_run("second data write was not held off while the first frame was sent");
		repeat (TEST_DIV + 1) @(posedge clk_bufg);   // receiver finishes its stop bit
		io_read(DAT_ADDR, rd, lat);
		check_word(rd, {24'h0, b2}, "looped back byte");
		loop_en = 1'b0;
	endtask

	task automatic test_receive();
		logic [IO_DW-1:0] rd;
		logic [7:0] b;
		int lat;
		b = 8'($urandom);
		send_frame(TEST_DIV, b);
		io_read(DAT_ADDR, rd, lat);
		check_word(IO_DW'(lat), 32'd1, "data read latency");
		check_word(rd, {24'h0, b}, "received byte");
		io_read(DAT_ADDR, rd, lat);
		check_word(rd, '1, "read with empty rx buffer");
	endtask

	initial begin
		void'($urandom(48579));
		resetn      = 1'b0;
		iomem_valid = 1'b0;
		iomem_wstrb = '0;
		iomem_addr  = '0;
		iomem_wdata = '0;
		sw          = HALF_W'($urandom);
		loop_en     = 1'b0;
		rx_drv      = 1'b1;   // line idles high
		gpio_model  = '0;
		repeat (3) @(posedge clk_bufg);
		#2;
		resetn = 1'b1;
		wait_reset_release();
		test_reset_state();
		test_gpio_strobes();
		test_decode();
		test_transmit();
		test_receive();
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
rtl/soc_io_pkg.sv
rtl/reset_gen.sv
rtl/iomem_decode.sv
rtl/gpio_regs.sv
rtl/simple_uart.sv
rtl/basys3_io_top.sv
bench/tb_basys3_io.sv

/* Makefile */
# Verilator build and run of the basys3 io testbench
# make sim decides pass or fail from the simulation output

VERILATOR ?= verilator
TOP       ?= tb_basys3_io
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
